// File: cart_pkg.sv
package cart_pkg;

	// ====================
	// Download stream
	// ====================

	// One host download beat
	typedef struct packed {
		logic        wr;
		logic [24:0] addr;
		logic [15:0] data;
	} dl_word_t;

	// Decoded download state, shared by all loaders
	typedef struct packed {
		logic cart_active;
		logic cart_start;
		logic cart_end;
		logic cart_wr;
		logic code_wr;
	} dl_ctrl_t;

	localparam logic [7:0] CART_INDEX = 8'd0;
	localparam logic [7:0] CODE_INDEX = 8'd63;

	// ====================
	// Cartridge header
	// ====================

	typedef struct packed {
		logic [7:0]  rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
		logic        pal;
	} cart_info_t;

	typedef enum logic [2:0] {
		AUTO      = 3'd0,
		NO_HEADER = 3'd1,
		LOROM     = 3'd2,
		HIROM     = 3'd3,
		EXHIROM   = 3'd4
	} header_mode_e;

	localparam logic [24:0] COPIER_HEADER_BYTES = 25'd512;
	localparam logic [24:0] LOROM_INFO_ADDR     = 25'h0007FD6;
	localparam logic [24:0] HIROM_INFO_ADDR     = 25'h000FFD6;
	localparam logic [24:0] EXHIROM_INFO_ADDR   = 25'h040FFD6;
	// RAM size word follows the ROM size word
	localparam logic [24:0] RAM_SIZE_OFFSET     = 25'd2;
	localparam logic [3:0]  DEFAULT_ROM_SIZE    = 4'd12;

	// ====================
	// Cheats and backup
	// ====================

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	// Loaded as 16-bit words, consumed as fields
	typedef union packed {
		cheat_fields_t     f;
		logic [7:0][15:0]  w;
	} cheat_code_u;

	localparam int unsigned SECTOR_SHIFT = 9;

endpackage

// File: download_router.sv
`timescale 1ns/1ps

module download_router (
	input  logic                clk_sys,
	input  logic                reset,
	input  cart_pkg::dl_word_t  dl,
	input  logic [7:0]          dl_index,
	input  logic                dl_busy,
	output cart_pkg::dl_ctrl_t  ctrl,
	output cart_pkg::dl_word_t  word
);

	logic cart_sel;
	logic code_sel;

	// Index qualifies the busy level
	assign cart_sel = dl_busy && (dl_index == cart_pkg::CART_INDEX);
	assign code_sel = dl_busy && (dl_index == cart_pkg::CODE_INDEX);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ctrl <= '0;
		end else begin
			ctrl.cart_active <= cart_sel;
			// Edges of the registered level, aligned with it
			ctrl.cart_start  <= cart_sel & ~ctrl.cart_active;
			ctrl.cart_end    <= ~cart_sel & ctrl.cart_active;
			ctrl.cart_wr     <= cart_sel & dl.wr;
			ctrl.code_wr     <= code_sel & dl.wr;
		end
	end

	// Beat copy lines up with the strobes above
	always_ff @(posedge clk_sys) begin
		word <= dl;
	end

endmodule

// File: rom_header_detect.sv
`timescale 1ns/1ps

module rom_header_detect (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  cart_pkg::dl_ctrl_t     ctrl,
	input  cart_pkg::dl_word_t     word,
	input  cart_pkg::header_mode_e header_mode,
	input  logic [1:0]             region_sel,
	output cart_pkg::cart_info_t   info
);

	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic [7:0]  rom_type;
	logic        rom_region;
	logic        pal;
	logic [23:0] rom_mask;
	logic [23:0] ram_mask;
	logic        has_info;
	logic [24:0] info_addr;
	logic [24:0] rom_size_addr;
	logic [24:0] ram_size_addr;

	// ====================
	// Info block location
	// ====================

	always_comb begin
		has_info  = 1'b1;
		info_addr = cart_pkg::LOROM_INFO_ADDR;
		case (header_mode)
			cart_pkg::LOROM:   info_addr = cart_pkg::LOROM_INFO_ADDR;
			cart_pkg::HIROM:   info_addr = cart_pkg::HIROM_INFO_ADDR;
			cart_pkg::EXHIROM: info_addr = cart_pkg::EXHIROM_INFO_ADDR;
			default:           has_info  = 1'b0;
		endcase
	end

	// Download still carries the copier header
	assign rom_size_addr = info_addr + cart_pkg::COPIER_HEADER_BYTES;
	assign ram_size_addr = rom_size_addr + cart_pkg::RAM_SIZE_OFFSET;

	// ====================
	// Header capture
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_size   <= cart_pkg::DEFAULT_ROM_SIZE;
			ram_size   <= 4'd0;
			rom_type   <= 8'd0;
			rom_region <= 1'b0;
		end else if (ctrl.cart_wr) begin
			if (word.addr == 25'd0) begin
				rom_size <= cart_pkg::DEFAULT_ROM_SIZE;
				ram_size <= 4'd0;
				// Packed sizes from the loader, RAM in the upper nibble
				if (header_mode == cart_pkg::AUTO && word.data[7:0] != 8'd0) begin
					{ram_size, rom_size} <= word.data[7:0];
				end
				case (header_mode)
					cart_pkg::AUTO:    rom_type <= word.data[15:8];
					cart_pkg::HIROM:   rom_type <= 8'd1;
					cart_pkg::EXHIROM: rom_type <= 8'd2;
					default:           rom_type <= 8'd0;
				endcase
			end
			if (word.addr == 25'd2) begin
				rom_region <= word.data[8];
			end
			if (has_info && word.addr == rom_size_addr) begin
				rom_size <= word.data[11:8];
			end
			if (has_info && word.addr == ram_size_addr) begin
				ram_size <= word.data[3:0];
			end
		end
	end

	// Masks trail the size registers by one cycle
	always_ff @(posedge clk_sys) begin
		rom_mask <= (24'd1024 << rom_size) - 24'd1;
		ram_mask <= (ram_size != 4'd0) ? (24'd1024 << ram_size) - 24'd1 : 24'd0;
	end

	// Region only switches outside a download
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pal <= 1'b0;
		end else if (!ctrl.cart_active) begin
			pal <= (region_sel == 2'd0) ? rom_region : region_sel[1];
		end
	end

	assign info = '{rom_type: rom_type, rom_mask: rom_mask, ram_mask: ram_mask, pal: pal};

	a_rom_mask_set: assert property (
		@(posedge clk_sys) disable iff (reset)
		ctrl.cart_wr |-> ##2 (info.rom_mask != 24'd0)
	) else $error("rom_mask is zero after a header write");

endmodule

// File: cheat_code_assembler.sv
`timescale 1ns/1ps

module cheat_code_assembler (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  cart_pkg::dl_ctrl_t    ctrl,
	input  cart_pkg::dl_word_t    word,
	output cart_pkg::cheat_code_u code,
	output logic                  code_valid,
	output logic                  code_clear
);

	logic [2:0] word_sel;
	logic       first_word;
	logic       last_word;

	// Offsets 0..14 map to words 6,7,4,5,2,3,0,1
	assign word_sel   = word.addr[3:1] ^ 3'd6;
	assign first_word = (word.addr[3:0] == 4'd0);
	assign last_word  = (word.addr[3:0] == 4'd14);

	// Record keeps its value until the next write
	always_ff @(posedge clk_sys) begin
		if (ctrl.code_wr) begin
			code.w[word_sel] <= word.data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			code_valid <= 1'b0;
			code_clear <= 1'b0;
		end else begin
			code_valid <= ctrl.code_wr & last_word;
			// Old codes are dropped on a new cartridge or a new code list
			code_clear <= ctrl.cart_active | (ctrl.code_wr & first_word);
		end
	end

	a_valid_pulse: assert property (
		@(posedge clk_sys) disable iff (reset)
		code_valid |=> !code_valid
	) else $error("code_valid held for two cycles");

endmodule

// File: ram_clear_sequencer.sv
`timescale 1ns/1ps

module ram_clear_sequencer #(
	parameter int FILL_ADDR_BITS = 17
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  cart_pkg::dl_ctrl_t        ctrl,
	input  logic [1:0]                fill_sel,
	output logic                      clearing,
	output logic                      fill_we,
	output logic [FILL_ADDR_BITS-1:0] fill_addr,
	output logic [7:0]                fill_data
);

	logic last_addr;

	assign last_addr = &fill_addr;

	// ====================
	// Address sweep
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clearing  <= 1'b0;
			fill_we   <= 1'b0;
			fill_addr <= '0;
		end else if (ctrl.cart_start) begin
			// Restart from zero even if a clear is still running
			clearing  <= 1'b1;
			fill_we   <= 1'b1;
			fill_addr <= '0;
		end else if (clearing) begin
			fill_addr <= fill_addr + 1'b1;
			if (last_addr) begin
				clearing <= 1'b0;
				fill_we  <= 1'b0;
			end
		end
	end

	// ====================
	// Power-on pattern
	// ====================

	always_comb begin
		case (fill_sel)
			2'd0: fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			2'd1: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			2'd2: fill_data = 8'h55;
			default: fill_data = 8'hFF;
		endcase
	end

	a_we_in_clear: assert property (
		@(posedge clk_sys) disable iff (reset)
		fill_we |-> clearing
	) else $error("fill_we outside a clear");

endmodule

// File: backup_sync_ctrl.sv
`timescale 1ns/1ps

module backup_sync_ctrl (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  cart_pkg::dl_ctrl_t   ctrl,
	input  cart_pkg::cart_info_t info,
	input  logic                 img_mounted,
	input  logic                 img_readonly,
	input  logic                 img_present,
	input  logic                 bk_load_req,
	input  logic                 bk_save_req,
	input  logic                 autosave,
	input  logic                 osd_open,
	input  logic                 bram_write,
	input  logic                 sd_ack,
	output logic                 sd_rd,
	output logic                 sd_wr,
	output logic [31:0]          sd_lba,
	output logic                 bk_busy,
	output logic                 bk_loading,
	output logic                 bk_pending
);

	logic        bk_ena;
	logic        load_q;
	logic        save_q;
	logic        ack_q;
	logic        start_load;
	logic        start_save;
	logic        start_op;
	logic [31:0] last_lba;

	assign last_lba = 32'(info.ram_mask) >> cart_pkg::SECTOR_SHIFT;

	// Load wins if both arrive together
	assign start_load = bk_ena & ((bk_load_req & ~load_q) | (ctrl.cart_end & img_present));
	assign start_save = bk_ena & ((bk_save_req & ~save_q) | (osd_open & autosave & bk_pending));
	assign start_op   = ~bk_busy & (start_load | start_save);

	// ====================
	// Enable and dirty flag
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
			load_q     <= 1'b0;
			save_q     <= 1'b0;
		end else begin
			load_q <= bk_load_req;
			save_q <= bk_save_req;
			if (ctrl.cart_start) begin
				bk_ena <= 1'b0;
			end else if (ctrl.cart_active && img_mounted && !img_readonly) begin
				bk_ena <= |info.ram_mask;
			end
			if (start_op) begin
				bk_pending <= 1'b0;
			end
			// A write in the same cycle still marks the RAM dirty
			if (bram_write && !osd_open) begin
				bk_pending <= 1'b1;
			end
		end
	end

	// ====================
	// Sector sequencer
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= 32'd0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
			ack_q      <= 1'b0;
		end else begin
			ack_q <= sd_ack;
			// Request accepted
			if (sd_ack && !ack_q) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end
			if (!bk_busy) begin
				if (start_op) begin
					bk_busy    <= 1'b1;
					bk_loading <= start_load;
					sd_lba     <= 32'd0;
					sd_rd      <= start_load;
					sd_wr      <= ~start_load;
				end
			end else if (ack_q && !sd_ack) begin
				// Sector done, move on or finish
				if (sd_lba >= last_lba) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 32'd1;
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

	a_one_request: assert property (
		@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr)
	) else $error("sd_rd and sd_wr both high");

endmodule

// File: cart_loader_top.sv
`timescale 1ns/1ps

module cart_loader_top #(
	parameter int FILL_ADDR_BITS = 17
) (
	input  logic                      clk_sys,
	input  logic                      reset,

	// Host download
	input  cart_pkg::dl_word_t        dl,
	input  logic [7:0]                dl_index,
	input  logic                      dl_busy,

	// User settings
	input  cart_pkg::header_mode_e    header_mode,
	input  logic [1:0]                region_sel,
	input  logic [1:0]                fill_sel,
	input  logic                      autosave,
	input  logic                      bk_load_req,
	input  logic                      bk_save_req,
	input  logic                      osd_open,

	// Block device and core
	input  logic                      img_mounted,
	input  logic                      img_readonly,
	input  logic                      img_present,
	input  logic                      sd_ack,
	input  logic                      bram_write,

	output cart_pkg::cart_info_t      info,
	output cart_pkg::cheat_code_u     code,
	output logic                      code_valid,
	output logic                      code_clear,
	output logic                      clearing,
	output logic                      fill_we,
	output logic [FILL_ADDR_BITS-1:0] fill_addr,
	output logic [7:0]                fill_data,
	output logic                      sd_rd,
	output logic                      sd_wr,
	output logic [31:0]               sd_lba,
	output logic                      bk_busy,
	output logic                      bk_loading,
	output logic                      bk_pending
);

	cart_pkg::dl_ctrl_t ctrl;
	cart_pkg::dl_word_t word;

	download_router u_router (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl      (dl),
		.dl_index(dl_index),
		.dl_busy (dl_busy),
		.ctrl    (ctrl),
		.word    (word)
	);

	rom_header_detect u_header (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ctrl       (ctrl),
		.word       (word),
		.header_mode(header_mode),
		.region_sel (region_sel),
		.info       (info)
	);

	cheat_code_assembler u_cheat (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ctrl      (ctrl),
		.word      (word),
		.code      (code),
		.code_valid(code_valid),
		.code_clear(code_clear)
	);

	ram_clear_sequencer #(
		.FILL_ADDR_BITS(FILL_ADDR_BITS)
	) u_clear (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.ctrl     (ctrl),
		.fill_sel (fill_sel),
		.clearing (clearing),
		.fill_we  (fill_we),
		.fill_addr(fill_addr),
		.fill_data(fill_data)
	);

	backup_sync_ctrl u_backup (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ctrl        (ctrl),
		.info        (info),
		.img_mounted (img_mounted),
		.img_readonly(img_readonly),
		.img_present (img_present),
		.bk_load_req (bk_load_req),
		.bk_save_req (bk_save_req),
		.autosave    (autosave),
		.osd_open    (osd_open),
		.bram_write  (bram_write),
		.sd_ack      (sd_ack),
		.sd_rd       (sd_rd),
		.sd_wr       (sd_wr),
		.sd_lba      (sd_lba),
		.bk_busy     (bk_busy),
		.bk_loading  (bk_loading),
		.bk_pending  (bk_pending)
	);

endmodule

// File: tb_cart_loader.sv
`timescale 1ns/1ps

module tb_cart_loader;

	localparam int FILL_BITS  = 10;
	localparam int FILL_WORDS = 1 << FILL_BITS;
	// Four full clears dominate the run, the rest is margin
	localparam int TIMEOUT_CYCLES = 4 * (FILL_WORDS + 20) + 1900;
	localparam int BUSY_LIMIT     = 200;

	logic                   clk_sys = 1'b0;
	logic                   reset;
	cart_pkg::dl_word_t     dl;
	logic [7:0]             dl_index;
	logic                   dl_busy;
	cart_pkg::header_mode_e header_mode;
	logic [1:0]             region_sel;
	logic [1:0]             fill_sel;
	logic                   autosave;
	logic                   bk_load_req;
	logic                   bk_save_req;
	logic                   osd_open;
	logic                   img_mounted;
	logic                   img_readonly;
	logic                   img_present;
	logic                   sd_ack;
	logic                   bram_write;

	cart_pkg::cart_info_t   info;
	cart_pkg::cheat_code_u  code;
	logic                   code_valid;
	logic                   code_clear;
	logic                   clearing;
	logic                   fill_we;
	logic [FILL_BITS-1:0]   fill_addr;
	logic [7:0]             fill_data;
	logic                   sd_rd;
	logic                   sd_wr;
	logic [31:0]            sd_lba;
	logic                   bk_busy;
	logic                   bk_loading;
	logic                   bk_pending;

	integer      seed        = 64660;
	int          error_count = 0;
	int          check_count = 0;
	int          cycle_count = 0;
	int          dev_wait    = 0;
	logic [31:0] sector_lba[$];
	logic [1:0]  sector_dir[$];

	cart_loader_top #(
		.FILL_ADDR_BITS(FILL_BITS)
	) DUT (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.dl_index    (dl_index),
		.dl_busy     (dl_busy),
		.header_mode (header_mode),
		.region_sel  (region_sel),
		.fill_sel    (fill_sel),
		.autosave    (autosave),
		.bk_load_req (bk_load_req),
		.bk_save_req (bk_save_req),
		.osd_open    (osd_open),
		.img_mounted (img_mounted),
		.img_readonly(img_readonly),
		.img_present (img_present),
		.sd_ack      (sd_ack),
		.bram_write  (bram_write),
		.info        (info),
		.code        (code),
		.code_valid  (code_valid),
		.code_clear  (code_clear),
		.clearing    (clearing),
		.fill_we     (fill_we),
		.fill_addr   (fill_addr),
		.fill_data   (fill_data),
		.sd_rd       (sd_rd),
		.sd_wr       (sd_wr),
		.sd_lba      (sd_lba),
		.bk_busy     (bk_busy),
		.bk_loading  (bk_loading),
		.bk_pending  (bk_pending)
	);

	always #50 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycle_count);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// ====================
	// Block device model
	// ====================

	// Ack 3 cycles after a request, held for 4, sector logged on accept
	always @(posedge clk_sys) begin
		#5;
		if (reset) begin
			sd_ack   = 1'b0;
			dev_wait = 0;
		end else if (sd_ack) begin
			dev_wait = dev_wait + 1;
			if (dev_wait == 4) begin
				sd_ack   = 1'b0;
				dev_wait = 0;
			end
		end else if (sd_rd || sd_wr) begin
			dev_wait = dev_wait + 1;
			if (dev_wait == 3) begin
				sd_ack   = 1'b1;
				dev_wait = 0;
				sector_lba.push_back(sd_lba);
				sector_dir.push_back({sd_rd, sd_wr});
			end
		end
	end

	// ====================
	// Helpers
	// ====================

	task automatic tick();
		@(posedge clk_sys);
		#5;
	endtask

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("ERR %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
		end
	endtask

	task automatic report_failure(input string what);
		error_count++;
		$display("Failure at %0t: %s", $time, what);
	endtask

	// Low 10 + size bits set, capped at the 24-bit mask width
	function automatic logic [23:0] mask_of(input logic [3:0] size);
		logic [23:0] m;
		for (int i = 0; i < 24; i++) begin
			m[i] = (i < 10 + size);
		end
		return m;
	endfunction

	function automatic logic [7:0] fill_pattern(input logic [FILL_BITS-1:0] a,
			input logic [1:0] sel);
		case (sel)
			2'd0: return (a[8] != a[2]) ? 8'h66 : 8'h99;
			2'd1: return (a[9] != a[0]) ? 8'hFF : 8'h00;
			2'd2: return 8'h55;
			default: return 8'hFF;
		endcase
	endfunction

	task automatic dl_open(input logic [7:0] index);
		dl_index = index;
		dl_busy  = 1'b1;
		tick();
	endtask

	task automatic dl_write(input logic [24:0] addr, input logic [15:0] data);
		dl = '{wr: 1'b1, addr: addr, data: data};
		tick();
		dl.wr = 1'b0;
	endtask

	task automatic dl_close();
		dl_busy = 1'b0;
		tick();
	endtask

	task automatic wait_busy(input logic level);
		int n;
		n = 0;
		while (bk_busy !== level && n < BUSY_LIMIT) begin
			tick();
			n++;
		end
		if (bk_busy !== level) begin
			report_failure($sformatf("bk_busy never reached %0d", level));
		end
	endtask

	task automatic check_sectors(input logic [1:0] dir);
		check("sector count", sector_lba.size(), 4);
		foreach (sector_lba[i]) begin
			check("sd_lba", sector_lba[i], i);
			check("{sd_rd,sd_wr}", sector_dir[i], dir);
		end
	endtask

	// ====================
	// Tests
	// ====================

	task automatic test_reset_state();
		check("code_valid", code_valid, 0);
		check("clearing", clearing, 0);
		check("fill_we", fill_we, 0);
		check("sd_rd", sd_rd, 0);
		check("sd_wr", sd_wr, 0);
		check("bk_busy", bk_busy, 0);
		check("bk_loading", bk_loading, 0);
		check("bk_pending", bk_pending, 0);
	endtask

	task automatic test_auto_header();
		logic [31:0] r;
		logic [3:0]  rom_n;
		logic [3:0]  ram_n;
		r = $random(seed);
		rom_n = (r[3:0] == 4'd0) ? 4'd1 : r[3:0];
		ram_n = (r[7:4] == 4'd0) ? 4'd1 : r[7:4];
		header_mode = cart_pkg::AUTO;
		dl_open(cart_pkg::CART_INDEX);
		dl_write(25'd0, {r[15:8], ram_n, rom_n});
		repeat (3) tick();
		check("info.rom_type", info.rom_type, r[15:8]);
		check("info.rom_mask", info.rom_mask, mask_of(rom_n));
		check("info.ram_mask", info.ram_mask, mask_of(ram_n));
		dl_close();
	endtask

	task automatic test_fixed_header(input cart_pkg::header_mode_e mode,
			input logic [24:0] info_addr, input logic [7:0] exp_type);
		logic [31:0] r;
		logic [3:0]  rom_n;
		logic [3:0]  ram_n;
		r = $random(seed);
		rom_n = 4'd1 + (r[3:0] % 4'd11);
		ram_n = 4'd1 + r[6:4];
		header_mode = mode;
		region_sel  = 2'd0;
		dl_open(cart_pkg::CART_INDEX);
		dl_write(25'd0, r[31:16]);
		dl_write(25'd2, {7'd0, r[8], 8'd0});
		// Copier header shifts the info block by 512 bytes
		dl_write(info_addr + 25'd512, {4'd0, rom_n, 8'd0});
		dl_write(info_addr + 25'd514, {12'd0, ram_n});
		repeat (3) tick();
		check("info.rom_type", info.rom_type, exp_type);
		check("info.rom_mask", info.rom_mask, mask_of(rom_n));
		check("info.ram_mask", info.ram_mask, mask_of(ram_n));
		dl_close();
		repeat (2) tick();
		check("info.pal", info.pal, r[8]);
		region_sel = 2'd1;
		repeat (2) tick();
		check("info.pal", info.pal, 0);
		region_sel = 2'd2;
		repeat (2) tick();
		check("info.pal", info.pal, 1);
		region_sel = 2'd0;
	endtask

	task automatic test_cheat();
		logic [15:0] d[8];
		logic [31:0] r;
		int          pulses;
		int          i;
		pulses = 0;
		dl_open(cart_pkg::CART_INDEX);
		tick();
		check("code_clear", code_clear, 1);
		dl_close();
		dl_open(cart_pkg::CODE_INDEX);
		for (i = 0; i < 8; i++) begin
			r = $random(seed);
			d[i] = r[15:0];
			dl_write(25'(2 * i), d[i]);
			if (code_valid) pulses++;
		end
		dl_busy = 1'b0;
		repeat (4) begin
			tick();
			if (code_valid) pulses++;
		end
		check("code_valid pulses", pulses, 1);
		// Each field is a little-endian pair of words
		check("code.f.flags", code.f.flags, {d[1], d[0]});
		check("code.f.address", code.f.address, {d[3], d[2]});
		check("code.f.compare", code.f.compare, {d[5], d[4]});
		check("code.f.replace", code.f.replace, {d[7], d[6]});
	endtask

	task automatic test_ram_clear(input logic [1:0] sel);
		int   beats;
		int   n;
		logic seen;
		beats = 0;
		n     = 0;
		seen  = 1'b0;
		fill_sel = sel;
		dl_open(cart_pkg::CART_INDEX);
		dl_busy = 1'b0;
		while (!(seen && !clearing) && n < FILL_WORDS + 20) begin
			tick();
			if (fill_we) begin
				check("fill_addr", fill_addr, beats);
				check("fill_data", fill_data, fill_pattern(fill_addr, sel));
				beats++;
			end
			if (clearing) seen = 1'b1;
			n++;
		end
		if (!(seen && !clearing)) begin
			report_failure($sformatf("clear with fill_sel %0d did not finish", sel));
		end
		check("fill_we beats", beats, FILL_WORDS);
		check("clearing", clearing, 0);
	endtask

	task automatic test_backup_save();
		header_mode = cart_pkg::AUTO;
		img_present = 1'b0;
		dl_open(cart_pkg::CART_INDEX);
		// RAM size 1 and ROM size 12
		dl_write(25'd0, 16'h001C);
		repeat (4) tick();
		dl_close();
		tick();
		check("info.ram_mask", info.ram_mask, 24'h7FF);
		check("bk_pending", bk_pending, 0);
		bram_write = 1'b1;
		tick();
		bram_write = 1'b0;
		check("bk_pending", bk_pending, 1);
		sector_lba.delete();
		sector_dir.delete();
		bk_save_req = 1'b1;
		wait_busy(1'b1);
		check("bk_loading", bk_loading, 0);
		wait_busy(1'b0);
		bk_save_req = 1'b0;
		check_sectors(2'b01);
		check("bk_pending", bk_pending, 0);
	endtask

	task automatic test_auto_load();
		img_present = 1'b1;
		sector_lba.delete();
		sector_dir.delete();
		dl_open(cart_pkg::CART_INDEX);
		dl_write(25'd0, 16'h001C);
		repeat (4) tick();
		dl_close();
		wait_busy(1'b1);
		check("bk_loading", bk_loading, 1);
		wait_busy(1'b0);
		check_sectors(2'b10);
		check("bk_loading", bk_loading, 0);
		img_present = 1'b0;
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		reset        = 1'b1;
		dl           = '0;
		dl_index     = 8'd0;
		dl_busy      = 1'b0;
		header_mode  = cart_pkg::AUTO;
		region_sel   = 2'd0;
		fill_sel     = 2'd0;
		autosave     = 1'b0;
		bk_load_req  = 1'b0;
		bk_save_req  = 1'b0;
		osd_open     = 1'b0;
		img_mounted  = 1'b1;
		img_readonly = 1'b0;
		img_present  = 1'b0;
		sd_ack       = 1'b0;
		bram_write   = 1'b0;
		repeat (8) @(posedge clk_sys);
		#5;
		reset = 1'b0;
		tick();

		test_reset_state();
		test_auto_header();
		test_fixed_header(cart_pkg::LOROM, 25'h7FD6, 8'd0);
		test_fixed_header(cart_pkg::HIROM, 25'hFFD6, 8'd1);
		test_cheat();
		for (int s = 0; s < 4; s++) begin
			test_ram_clear(2'(s));
		end
		test_backup_save();
		test_auto_load();

		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: cart_loader.f
cart_pkg.sv
download_router.sv
rom_header_detect.sv
cheat_code_assembler.sv
ram_clear_sequencer.sv
backup_sync_ctrl.sv
cart_loader_top.sv
tb_cart_loader.sv

// File: Bender.yml
package:
  name: cart_loader

sources:
  - cart_pkg.sv
  - download_router.sv
  - rom_header_detect.sv
  - cheat_code_assembler.sv
  - ram_clear_sequencer.sv
  - backup_sync_ctrl.sv
  - cart_loader_top.sv
  - target: simulation
    files:
      - tb_cart_loader.sv
